/* sim.f */
+incdir+src
src/glb_pkg.sv
src/glb_cfg_decode.sv
src/glb_host_router.sv
src/glb_bank.sv
src/glb_rd_return.sv
src/global_buffer.sv
verification/global_buffer_checker.sv
verification/global_buffer_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = global_buffer_tb
FILELIST  = sim.f
LOG       = sim.log
BIN       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* verification/global_buffer_tb.sv */
// ======================================================================
// self-checking testbench for the global buffer
// drives host and config traffic, checks against a reference model
// ======================================================================

`timescale 1ns/100ps
`include "glb_macros.svh"

module global_buffer_tb;

    localparam int CLK_HALF  = 50;
    localparam int DRV_DLY   = 10;
    localparam int GA_W      = `GLB_BANK_SEL_W + `GLB_BANK_ADDR_W;
    localparam int NUM_WORDS = 2 ** GA_W;
    localparam int T1_OPS    = NUM_WORDS + 64;
    localparam int T2_OPS    = 2 * `GLB_RET_DEPTH + 4;
    localparam int T3_OPS    = 200;
    localparam int T4_OPS    = 2 * `GLB_NUM_BANKS + 2;
    localparam int T5_OPS    = 3 * `GLB_NUM_BANKS + 4;
    localparam int TOTAL_OPS = T1_OPS + T2_OPS + T3_OPS + T4_OPS + T5_OPS;

    logic                   clk;
    logic                   arst_n;
    logic                   req_valid;
    logic                   req_ready;
    glb_pkg::glb_host_req_t req;
    logic                   rsp_valid;
    logic                   rsp_ready;
    glb_pkg::glb_data_t     rsp_data;
    logic                   cfg_wr;
    logic                   cfg_rd;
    glb_pkg::cfg_addr_t     cfg_addr;
    glb_pkg::cfg_data_t     cfg_wdata;
    glb_pkg::cfg_data_t     cfg_rdata;

    // reference model state
    glb_pkg::glb_data_t     mem_model [NUM_WORDS];
    glb_pkg::cfg_data_t     ctrl_model [`GLB_NUM_BANKS];
    glb_pkg::cfg_data_t     wr_count [`GLB_NUM_BANKS];
    glb_pkg::glb_data_t     exp_q [$];

    logic [31:0]            stim_seed;
    logic [31:0]            rdy_seed;
    logic                   rdy_random;
    int                     errors;
    int                     rsp_total;
    int                     stall_cycles;

    global_buffer dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .cfg_wr    (cfg_wr),
        .cfg_rd    (cfg_rd),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    bind global_buffer global_buffer_checker checker_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .cfg_rdata (cfg_rdata)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic glb_pkg::cfg_addr_t cfg_addr_of(input int block, input int bank,
                                                       input logic reg_sel);
        glb_pkg::cfg_addr_t a;
        a = '0;
        a[`GLB_CFG_ADDR_W-1 -: `GLB_CFG_BLOCK_W] = block[`GLB_CFG_BLOCK_W-1:0];
        a[`GLB_CFG_BANK_LSB +: `GLB_BANK_SEL_W]  = bank[`GLB_BANK_SEL_W-1:0];
        a[0] = reg_sel;
        return a;
    endfunction

    // expected host read word or config register value
    function automatic logic [31:0] expected_value(input logic is_cfg,
                                                   input glb_pkg::cfg_addr_t addr);
        int bank;
        bank = int'(addr[`GLB_CFG_BANK_LSB +: `GLB_BANK_SEL_W]);
        if (!is_cfg) begin
            return mem_model[addr[GA_W-1:0]];
        end else if (addr[`GLB_CFG_ADDR_W-1 -: `GLB_CFG_BLOCK_W] != `GLB_CFG_BLOCK_BANK) begin
            return '0;
        end
        return addr[0] ? wr_count[bank] : ctrl_model[bank];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("FAIL %s: got %h, expected %h", name, got, exp);
    endtask

    // called at the drive point, returns at the next drive point after the transfer
    task automatic send_req(input logic wr, input glb_pkg::glb_addr_t addr,
                            input glb_pkg::glb_data_t data);
        int bank;
        bank = int'(addr[GA_W-1 -: `GLB_BANK_SEL_W]);
        req_valid = 1'b1;
        req = '{wr: wr, addr: addr, data: data};
        stall_cycles = 0;
        @(negedge clk);
        while (!req_ready) begin
            stall_cycles++;
            @(negedge clk);
        end
        // transfer happens at the coming edge
        if (wr && !ctrl_model[bank][0]) begin
            mem_model[addr] = data;
            wr_count[bank] = wr_count[bank] + 1;
        end else if (!wr) begin
            exp_q.push_back(expected_value(1'b0, glb_pkg::cfg_addr_t'(addr)));
        end
        @(posedge clk);
        #DRV_DLY;
    endtask

    task automatic wait_drain();
        req_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #DRV_DLY;
        end
    endtask

    task automatic cfg_write(input glb_pkg::cfg_addr_t addr, input glb_pkg::cfg_data_t data);
        cfg_wr = 1'b1;
        cfg_addr = addr;
        cfg_wdata = data;
        @(posedge clk);
        #DRV_DLY;
        cfg_wr = 1'b0;
        if (addr[`GLB_CFG_ADDR_W-1 -: `GLB_CFG_BLOCK_W] == `GLB_CFG_BLOCK_BANK && !addr[0]) begin
            ctrl_model[addr[`GLB_CFG_BANK_LSB +: `GLB_BANK_SEL_W]] = data;
        end
    endtask

    task automatic cfg_check(input glb_pkg::cfg_addr_t addr);
        logic [31:0] exp;
        cfg_rd = 1'b1;
        cfg_addr = addr;
        @(posedge clk);
        #DRV_DLY;
        cfg_rd = 1'b0;
        exp = expected_value(1'b1, addr);
        if (cfg_rdata !== exp) report_mismatch("cfg_rdata", cfg_rdata, exp);
    endtask

    task automatic end_test(input string name, input int err_mark);
        $display("test %s: %0d errors", name, errors - err_mark);
    endtask

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // random response back-pressure
    initial begin
        forever begin
            @(posedge clk);
            #DRV_DLY;
            if (rdy_random) begin
                rdy_seed  = lcg_next(rdy_seed);
                rsp_ready = rdy_seed[16];
            end
        end
    end

    // response compare, sampled mid-cycle ahead of the transfer edge
    always @(negedge clk) begin : compare_rsp
        glb_pkg::glb_data_t exp_word;
        if (arst_n && rsp_valid && rsp_ready) begin
            rsp_total++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("a response arrived with no read outstanding");
            end else begin
                exp_word = exp_q.pop_front();
                if (rsp_data !== exp_word) report_mismatch("rsp_data", rsp_data, exp_word);
            end
        end
    end

    initial begin
        repeat (TOTAL_OPS * 20 + 200) @(posedge clk);
        $display("timeout: the run did not finish in %0d cycles", TOTAL_OPS * 20 + 200);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        glb_pkg::glb_addr_t addr;
        glb_pkg::bank_addr_t off;
        logic wr;
        int err_mark;
        int rsp_mark;
        int rd_count;
        int pbank;

        arst_n = 1'b0;
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b1;
        cfg_wr = 1'b0;
        cfg_rd = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        stim_seed = 32'h8e66;
        rdy_seed = ~32'h8e66;
        rdy_random = 1'b0;
        errors = 0;
        rsp_total = 0;
        for (int b = 0; b < `GLB_NUM_BANKS; b++) begin
            ctrl_model[b] = '0;
            wr_count[b] = '0;
        end
        repeat (8) @(posedge clk);
        #DRV_DLY;
        arst_n = 1'b1;
        @(posedge clk);
        #DRV_DLY;

        // fill every word, then random write/read pairs per bank
        err_mark = errors;
        for (int a = 0; a < NUM_WORDS; a++) begin
            addr = glb_pkg::glb_addr_t'(a);
            send_req(1'b1, addr, {8'h5a, addr, ~addr, addr ^ 8'hc3});
        end
        for (int b = 0; b < `GLB_NUM_BANKS; b++) begin
            for (int n = 0; n < 8; n++) begin
                stim_seed = lcg_next(stim_seed);
                addr = {glb_pkg::bank_sel_t'(b), glb_pkg::bank_addr_t'(stim_seed >> 16)};
                stim_seed = lcg_next(stim_seed);
                send_req(1'b1, addr, stim_seed);
                send_req(1'b0, addr, '0);
            end
        end
        wait_drain();
        end_test("1 write/read every bank", err_mark);

        // reads pile up with the response side stalled
        err_mark = errors;
        rsp_mark = rsp_total;
        rsp_ready = 1'b0;
        for (int n = 0; n < `GLB_RET_DEPTH; n++) begin
            stim_seed = lcg_next(stim_seed);
            addr = {glb_pkg::bank_sel_t'(n), glb_pkg::bank_addr_t'(stim_seed >> 16)};
            send_req(1'b0, addr, '0);
            if (stall_cycles != 0) begin
                errors++;
                $display("read %0d stalled while credits were left", n);
            end
        end
        stim_seed = lcg_next(stim_seed);
        addr = {glb_pkg::bank_sel_t'(`GLB_RET_DEPTH), glb_pkg::bank_addr_t'(stim_seed >> 16)};
        req = '{wr: 1'b0, addr: addr, data: '0};
        repeat (3) begin
            @(negedge clk);
            if (req_ready !== 1'b0) report_mismatch("req_ready", req_ready, 0);
            if (rsp_valid !== 1'b1) report_mismatch("rsp_valid", rsp_valid, 1);
            @(posedge clk);
            #DRV_DLY;
        end
        rsp_ready = 1'b1;
        send_req(1'b0, addr, '0);
        wait_drain();
        if (rsp_total - rsp_mark != `GLB_RET_DEPTH + 1) begin
            report_mismatch("response count", rsp_total - rsp_mark, `GLB_RET_DEPTH + 1);
        end
        end_test("2 credit back-pressure", err_mark);

        // mixed random stream with rsp_ready toggling
        err_mark = errors;
        rsp_mark = rsp_total;
        rd_count = 0;
        rdy_random = 1'b1;
        for (int n = 0; n < T3_OPS; n++) begin
            stim_seed = lcg_next(stim_seed);
            addr = glb_pkg::glb_addr_t'(stim_seed >> 20);
            wr = stim_seed[9];
            stim_seed = lcg_next(stim_seed);
            send_req(wr, addr, stim_seed);
            if (!wr) rd_count++;
        end
        wait_drain();
        rdy_random = 1'b0;
        rsp_ready = 1'b1;
        if (rsp_total - rsp_mark != rd_count) begin
            report_mismatch("response count", rsp_total - rsp_mark, rd_count);
        end
        end_test("3 random stream", err_mark);

        // protect one bank, then write the same word in all banks
        err_mark = errors;
        stim_seed = lcg_next(stim_seed);
        pbank = int'(stim_seed[17:16]);
        cfg_write(cfg_addr_of(`GLB_CFG_BLOCK_BANK, pbank, 1'b0), 32'h1);
        stim_seed = lcg_next(stim_seed);
        off = glb_pkg::bank_addr_t'(stim_seed >> 16);
        for (int b = 0; b < `GLB_NUM_BANKS; b++) begin
            stim_seed = lcg_next(stim_seed);
            send_req(1'b1, {glb_pkg::bank_sel_t'(b), off}, stim_seed);
        end
        for (int b = 0; b < `GLB_NUM_BANKS; b++) begin
            send_req(1'b0, {glb_pkg::bank_sel_t'(b), off}, '0);
        end
        wait_drain();
        end_test("4 write protect", err_mark);

        // status counters, control readback, other block codes
        err_mark = errors;
        for (int b = 0; b < `GLB_NUM_BANKS; b++) begin
            cfg_check(cfg_addr_of(`GLB_CFG_BLOCK_BANK, b, 1'b1));
        end
        for (int b = 0; b < `GLB_NUM_BANKS; b++) begin
            stim_seed = lcg_next(stim_seed);
            cfg_write(cfg_addr_of(`GLB_CFG_BLOCK_BANK, b, 1'b0), stim_seed);
            cfg_check(cfg_addr_of(`GLB_CFG_BLOCK_BANK, b, 1'b0));
        end
        cfg_write(cfg_addr_of(3, 1, 1'b0), 32'hffff_ffff);
        cfg_check(cfg_addr_of(3, 1, 1'b0));
        cfg_check(cfg_addr_of(`GLB_CFG_BLOCK_BANK, 1, 1'b0));
        end_test("5 config registers", err_mark);

        // handshake and reset assertion failures
        errors += dut_i.checker_i.fail_count;
        $display("summary: 5 tests, %0d responses, %0d errors", rsp_total, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verification/global_buffer_checker.sv */
// ======================================================================
// handshake and reset assertions for the global buffer
// bound onto the top level from the testbench
// ======================================================================

`timescale 1ns/100ps

module global_buffer_checker (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   req_valid,
    input logic                   req_ready,
    input glb_pkg::glb_host_req_t req,
    input logic                   rsp_valid,
    input logic                   rsp_ready,
    input glb_pkg::glb_data_t     rsp_data,
    input glb_pkg::cfg_data_t     cfg_rdata
);

    // failed assertions, summed into the testbench result
    int fail_count = 0;

    // stalled request held until accepted
    req_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else begin
            fail_count++;
            $error("host request changed while stalled");
        end

    rsp_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
        else begin
            fail_count++;
            $error("response data changed while stalled");
        end

    // empty queue and cleared readback in reset
    reset_a: assert property (@(posedge clk) !arst_n |-> !rsp_valid && cfg_rdata == '0)
        else begin
            fail_count++;
            $error("outputs not at reset values");
        end

endmodule

/* src/global_buffer.sv */
// ======================================================================
// global buffer top level
// host request/response channels and the configuration register port
// over GLB_NUM_BANKS banks; instances and wiring only
// ======================================================================

`timescale 1ns/100ps
`include "glb_macros.svh"

module global_buffer (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    input  glb_pkg::glb_host_req_t  req,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output glb_pkg::glb_data_t      rsp_data,
    input  logic                    cfg_wr,
    input  logic                    cfg_rd,
    input  glb_pkg::cfg_addr_t      cfg_addr,
    input  glb_pkg::cfg_data_t      cfg_wdata,
    output glb_pkg::cfg_data_t      cfg_rdata
);

    logic [`GLB_NUM_BANKS-1:0]                  bank_cmd_valid;
    glb_pkg::glb_bank_cmd_t                     bank_cmd;
    glb_pkg::glb_data_t [`GLB_NUM_BANKS-1:0]    bank_rd_data;
    logic                                       issue_valid;
    glb_pkg::bank_sel_t                         issue_tag;
    logic                                       ret_pop;
    glb_pkg::glb_cfg_cmd_t                      cfg_cmd;
    logic [`GLB_NUM_BANKS-1:0]                  cfg_sel;
    glb_pkg::cfg_data_t [`GLB_NUM_BANKS-1:0]    cfg_rdata_bank;

    glb_cfg_decode cfg_decode_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .cfg_wr         (cfg_wr),
        .cfg_rd         (cfg_rd),
        .cfg_addr       (cfg_addr),
        .cfg_wdata      (cfg_wdata),
        .cfg_cmd        (cfg_cmd),
        .cfg_sel        (cfg_sel),
        .cfg_rdata_bank (cfg_rdata_bank),
        .cfg_rdata      (cfg_rdata)
    );

    glb_host_router host_router_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req            (req),
        .bank_cmd_valid (bank_cmd_valid),
        .bank_cmd       (bank_cmd),
        .issue_valid    (issue_valid),
        .issue_tag      (issue_tag),
        .ret_pop        (ret_pop)
    );

    for (genvar i = 0; i < `GLB_NUM_BANKS; i++) begin : g_bank
        glb_bank bank_i (
            .clk       (clk),
            .arst_n    (arst_n),
            .cmd_valid (bank_cmd_valid[i]),
            .cmd       (bank_cmd),
            .rd_data   (bank_rd_data[i]),
            .cfg_sel   (cfg_sel[i]),
            .cfg_cmd   (cfg_cmd),
            .cfg_rdata (cfg_rdata_bank[i])
        );
    end

    glb_rd_return rd_return_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue_valid  (issue_valid),
        .issue_tag    (issue_tag),
        .bank_rd_data (bank_rd_data),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .rsp_data     (rsp_data),
        .ret_pop      (ret_pop)
    );

endmodule

/* src/glb_rd_return.sv */
// ======================================================================
// in-order read return queue
// captures the tagged bank's read word one cycle after issue and
// presents it on the valid/ready response channel
// ======================================================================

`timescale 1ns/100ps
`include "glb_macros.svh"

module glb_rd_return (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  logic                                    issue_valid,
    input  glb_pkg::bank_sel_t                      issue_tag,
    input  glb_pkg::glb_data_t [`GLB_NUM_BANKS-1:0] bank_rd_data,
    output logic                                    rsp_valid,
    input  logic                                    rsp_ready,
    output glb_pkg::glb_data_t                      rsp_data,
    output logic                                    ret_pop
);

    localparam int PTR_W = $clog2(`GLB_RET_DEPTH);

    glb_pkg::glb_data_t fifo_mem [`GLB_RET_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               push_q;
    glb_pkg::bank_sel_t tag_q;
    logic               pop;

    // bank data shows up one cycle after issue
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            push_q <= 1'b0;
        end else begin
            push_q <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        tag_q <= issue_tag;
        if (push_q) begin
            fifo_mem[wr_ptr] <= bank_rd_data[tag_q];
        end
    end

    assign rsp_valid = (count != '0);
    assign rsp_data  = fifo_mem[rd_ptr];
    assign pop       = rsp_valid && rsp_ready;
    assign ret_pop   = pop;

    // no overflow check, router credits bound the occupancy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_q) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_q, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/glb_bank.sv */
// ======================================================================
// one global buffer memory bank
// host word array with one-cycle reads, plus the bank's control
// register (bit 0 write protect) and accepted-write status counter
// ======================================================================

`timescale 1ns/100ps
`include "glb_macros.svh"

module glb_bank (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        cmd_valid,
    input  glb_pkg::glb_bank_cmd_t      cmd,
    output glb_pkg::glb_data_t          rd_data,
    input  logic                        cfg_sel,
    input  glb_pkg::glb_cfg_cmd_t       cfg_cmd,
    output glb_pkg::cfg_data_t          cfg_rdata
);

    localparam int WORDS = 2 ** `GLB_BANK_ADDR_W;

    glb_pkg::glb_data_t mem [WORDS];
    glb_pkg::cfg_data_t ctrl_reg;
    glb_pkg::cfg_data_t stat_reg;
    logic               wr_protect;
    logic               wr_ok;

    assign wr_protect = ctrl_reg[0];
    assign wr_ok      = cmd_valid && cmd.wr && !wr_protect;

    // word array
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[cmd.addr] <= cmd.data;
        end
        if (cmd_valid && !cmd.wr) begin
            rd_data <= mem[cmd.addr];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_reg <= '0;
        end else if (cfg_sel && cfg_cmd.wr && !cfg_cmd.reg_sel) begin
            ctrl_reg <= cfg_cmd.data;
        end
    end

    // status is read only, counts host writes that landed
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stat_reg <= '0;
        end else if (wr_ok) begin
            stat_reg <= stat_reg + 1'b1;
        end
    end

    always_comb begin
        cfg_rdata = '0;
        if (cfg_sel && cfg_cmd.rd) begin
            cfg_rdata = cfg_cmd.reg_sel ? stat_reg : ctrl_reg;
        end
    end

endmodule

/* src/glb_host_router.sv */
// ======================================================================
// host request router
// steers each accepted request to one bank in the same cycle and tags
// reads for the return queue; reads are throttled by queue credits
// ======================================================================

`timescale 1ns/100ps
`include "glb_macros.svh"

module glb_host_router (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            req_valid,
    output logic                            req_ready,
    input  glb_pkg::glb_host_req_t          req,
    output logic [`GLB_NUM_BANKS-1:0]       bank_cmd_valid,
    output glb_pkg::glb_bank_cmd_t          bank_cmd,
    output logic                            issue_valid,
    output glb_pkg::bank_sel_t              issue_tag,
    input  logic                            ret_pop
);

    localparam int CRED_W = $clog2(`GLB_RET_DEPTH + 1);

    logic [CRED_W-1:0]  credits;
    glb_pkg::bank_sel_t req_bank;
    logic               xfer;
    logic               rd_xfer;

    assign req_bank = req.addr[`GLB_BANK_SEL_W+`GLB_BANK_ADDR_W-1 -: `GLB_BANK_SEL_W];

    // writes never wait, reads need a free return entry
    assign req_ready = req.wr || (credits != '0);
    assign xfer      = req_valid && req_ready;
    assign rd_xfer   = xfer && !req.wr;

    always_comb begin
        for (int i = 0; i < `GLB_NUM_BANKS; i++) begin
            bank_cmd_valid[i] = xfer && (req_bank == glb_pkg::bank_sel_t'(i));
        end
    end

    assign bank_cmd.wr   = req.wr;
    assign bank_cmd.addr = req.addr[`GLB_BANK_ADDR_W-1:0];
    assign bank_cmd.data = req.data;

    assign issue_valid = rd_xfer;
    assign issue_tag   = req_bank;

    // one credit per queue entry, taken at issue and given back at pop
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= CRED_W'(`GLB_RET_DEPTH);
        end else begin
            case ({rd_xfer, ret_pop})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

/* src/glb_cfg_decode.sv */
// ======================================================================
// configuration port decoder
// turns the block and bank fields into per-bank selects and registers
// the merged bank readback one cycle after a read strobe
// ======================================================================

`timescale 1ns/100ps
`include "glb_macros.svh"

module glb_cfg_decode (
    input  logic                                        clk,
    input  logic                                        arst_n,
    input  logic                                        cfg_wr,
    input  logic                                        cfg_rd,
    input  glb_pkg::cfg_addr_t                          cfg_addr,
    input  glb_pkg::cfg_data_t                          cfg_wdata,
    output glb_pkg::glb_cfg_cmd_t                       cfg_cmd,
    output logic [`GLB_NUM_BANKS-1:0]                   cfg_sel,
    input  glb_pkg::cfg_data_t [`GLB_NUM_BANKS-1:0]     cfg_rdata_bank,
    output glb_pkg::cfg_data_t                          cfg_rdata
);

    logic               bank_blk_hit;
    glb_pkg::bank_sel_t cfg_bank;
    glb_pkg::cfg_data_t rdata_or;

    assign bank_blk_hit = (cfg_addr[`GLB_CFG_ADDR_W-1 -: `GLB_CFG_BLOCK_W] == `GLB_CFG_BLOCK_BANK);
    assign cfg_bank     = cfg_addr[`GLB_CFG_BANK_LSB +: `GLB_BANK_SEL_W];

    assign cfg_cmd.wr      = cfg_wr;
    assign cfg_cmd.rd      = cfg_rd;
    assign cfg_cmd.reg_sel = cfg_addr[0];
    assign cfg_cmd.data    = cfg_wdata;

    always_comb begin
        rdata_or = '0;
        for (int i = 0; i < `GLB_NUM_BANKS; i++) begin
            cfg_sel[i] = bank_blk_hit && (cfg_bank == glb_pkg::bank_sel_t'(i));
            // unselected banks drive zero
            rdata_or   = rdata_or | cfg_rdata_bank[i];
        end
    end

    // readback held until the next read strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_rdata <= '0;
        end else if (cfg_rd) begin
            cfg_rdata <= bank_blk_hit ? rdata_or : '0;
        end
    end

endmodule

/* src/glb_pkg.sv */
// ======================================================================
// shared types of the global buffer
// width typedefs and the packed request and command structs
// ======================================================================

`include "glb_macros.svh"

package glb_pkg;

    typedef logic [`GLB_BANK_SEL_W-1:0]                  bank_sel_t;
    typedef logic [`GLB_BANK_ADDR_W-1:0]                 bank_addr_t;
    // bank index sits above the word address
    typedef logic [`GLB_BANK_SEL_W+`GLB_BANK_ADDR_W-1:0] glb_addr_t;
    typedef logic [`GLB_DATA_W-1:0]                      glb_data_t;
    typedef logic [`GLB_CFG_ADDR_W-1:0]                  cfg_addr_t;
    typedef logic [`GLB_CFG_DATA_W-1:0]                  cfg_data_t;

    typedef struct packed {
        logic      wr;
        glb_addr_t addr;
        glb_data_t data;
    } glb_host_req_t;

    typedef struct packed {
        logic       wr;
        bank_addr_t addr;
        glb_data_t  data;
    } glb_bank_cmd_t;

    // reg_sel 0 is control, 1 is status
    typedef struct packed {
        logic      wr;
        logic      rd;
        logic      reg_sel;
        cfg_data_t data;
    } glb_cfg_cmd_t;

endpackage

/* src/glb_macros.svh */
// ======================================================================
// global buffer build parameters
// include wherever bank count, widths or config block codes are needed
// ======================================================================

`ifndef GLB_MACROS_SVH
`define GLB_MACROS_SVH

// bank organisation
`define GLB_NUM_BANKS       4
`define GLB_BANK_SEL_W      2
`define GLB_BANK_ADDR_W     6
`define GLB_DATA_W          32

// configuration port
`define GLB_CFG_ADDR_W      16
`define GLB_CFG_DATA_W      32
`define GLB_CFG_BLOCK_W     4
`define GLB_CFG_BLOCK_BANK  0
`define GLB_CFG_BANK_LSB    8

// read return queue entries, also the host read credit count
`define GLB_RET_DEPTH       4

`endif
